/* hw/grant_gather.sv */
`timescale 1ns/10ps
`default_nettype none

// forwards core requests to memory and holds back the grants
// until the whole batch has been granted
module grant_gather import lockstep_pkg::*; (
   input  wire logic       clk_i,
   input  wire logic       rst_ni,
   input  wire logic       same_address,  // all cores hit one address
   input  wire lane_mask_t req_i,         // held by the cores until gnt_o
   input  wire lane_mask_t gnt_i,         // one pulse per forwarded request
   output lane_mask_t      req_o,
   output lane_mask_t      gnt_o,
   output logic            grant_release  // batch fully granted this cycle
);

   count_t gnt_cnt_q;    // grants seen so far in this batch
   count_t gnt_now;      // grant pulses this cycle
   count_t gnt_total;    // counted plus this cycle
   count_t gnt_expected; // grants needed before release
   logic   release_now;

   // request forwarding
   always_comb begin
      req_o = '0;
      if (same_address) begin
         // one memory access serves the group, lane 0 carries it
         req_o[0] = |req_i;
      end else begin
         req_o = req_i; // independent accesses, pass all
      end
   end

   // how many grants close the batch
   always_comb begin
      if (same_address) begin
         gnt_expected = count_t'(1); // single shared access
      end else begin
         gnt_expected = popcount(req_i);
      end
   end

   assign gnt_now   = popcount(gnt_i);
   assign gnt_total = gnt_cnt_q + gnt_now;

   // release when the last outstanding grant shows up
   assign release_now = (gnt_expected != '0) && (gnt_total == gnt_expected);

   // every requester gets its grant in the same cycle
   assign gnt_o         = release_now ? req_i : '0;
   assign grant_release = release_now;

   // grant counter
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         gnt_cnt_q <= '0;
      end else if (release_now) begin
         gnt_cnt_q <= '0;        // batch closed, start over
      end else begin
         gnt_cnt_q <= gnt_total; // keep adding pulses
      end
   end

endmodule

`default_nettype wire

/* hw/lockstep_pkg.sv */
`default_nettype none

package lockstep_pkg;

   // lockstep group geometry
   localparam int n_lanes = 8;  // cores running in lockstep
   localparam int word_w  = 32; // data word of one core
   localparam int count_w = 4;  // holds 0 .. n_lanes

   typedef logic [n_lanes-1:0]        lane_mask_t; // one bit per core
   typedef logic [word_w-1:0]         word_t;
   typedef logic [n_lanes*word_w-1:0] lane_data_t; // lane i in word slice i
   typedef logic [count_w-1:0]        count_t;

   // number of set lanes in a mask
   function automatic count_t popcount(lane_mask_t mask);
      count_t ones;
      ones = '0;
      for (int i = 0; i < n_lanes; i++) begin
         ones = ones + count_t'(mask[i]);
      end
      return ones;
   endfunction

   // lane i word out of the packed bus
   function automatic word_t lane_word(lane_data_t data, int lane);
      word_t word;
      word = data[lane*word_w +: word_w];
      return word;
   endfunction

endpackage

`default_nettype wire

/* hw/lockstep_unit.sv */
`timescale 1ns/10ps
`default_nettype none

// memory front end for a group of lockstep cores
// grants and responses go back to the cores as whole batches
module lockstep_unit import lockstep_pkg::*; (
   input  wire logic       clk_i,
   input  wire logic       rst_ni,
   input  wire logic       same_address, // group accesses one address

   // core side requests
   input  wire lane_mask_t req_i,

   // memory side
   input  wire lane_mask_t gnt_i,
   input  wire lane_mask_t rvalid_i,
   input  wire lane_data_t rdata_i,

   output lane_mask_t      req_o,   // to memory
   output lane_mask_t      gnt_o,   // to cores, whole batch at once
   output lane_mask_t      rvalid_o,
   output lane_data_t      rdata_o
);

   logic grant_release; // batch fully granted

   // request forwarding and grant gathering
   grant_gather u_grant_gather (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .same_address  (same_address),
      .req_i         (req_i),
      .gnt_i         (gnt_i),
      .req_o         (req_o),
      .gnt_o         (gnt_o),
      .grant_release (grant_release)
   );

   // response gathering
   // batch mask latched from req_i at grant release
   response_gather u_response_gather (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .grant_release (grant_release),
      .req_i         (req_i),
      .same_address  (same_address),
      .rvalid_i      (rvalid_i),
      .rdata_i       (rdata_i),
      .rvalid_o      (rvalid_o),
      .rdata_o       (rdata_o)
   );

endmodule

`default_nettype wire

/* hw/response_gather.sv */
`timescale 1ns/10ps
`default_nettype none

// collects read responses of the outstanding batch and hands
// them to all requesting cores at once
module response_gather import lockstep_pkg::*; (
   input  wire logic       clk_i,
   input  wire logic       rst_ni,
   input  wire logic       grant_release, // batch granted, latch it
   input  wire lane_mask_t req_i,
   input  wire logic       same_address,
   input  wire lane_mask_t rvalid_i,      // one pulse per forwarded request
   input  wire lane_data_t rdata_i,       // valid where rvalid_i is high
   output lane_mask_t      rvalid_o,
   output lane_data_t      rdata_o
);

   lane_mask_t pending_q;     // cores waiting for data
   logic       shared_q;      // batch was a shared access
   count_t     rsp_cnt_q;     // responses seen so far
   count_t     rsp_now;       // responses counted this cycle
   count_t     rsp_total;
   count_t     rsp_expected;
   logic       batch_done;
   lane_data_t rdata_q;       // last word per lane
   word_t      word_now [n_lanes]; // freshest word per lane

   // responses that count toward the batch
   always_comb begin
      if (shared_q) begin
         rsp_now = count_t'(rvalid_i[0]); // only lane 0 went out
      end else begin
         rsp_now = popcount(rvalid_i);
      end
   end

   always_comb begin
      if (shared_q) begin
         rsp_expected = count_t'(1);
      end else begin
         rsp_expected = popcount(pending_q);
      end
   end

   assign rsp_total  = rsp_cnt_q + rsp_now;
   assign batch_done = (pending_q != '0) && (rsp_total == rsp_expected);

   // batch state
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pending_q <= '0;
         shared_q  <= 1'b0;
         rsp_cnt_q <= '0;
      end else begin
         if (grant_release) begin
            // next batch may be granted as the previous one completes
            pending_q <= req_i;
            shared_q  <= same_address;
         end else if (batch_done) begin
            pending_q <= '0;
            shared_q  <= 1'b0;
         end
         if (batch_done) begin
            rsp_cnt_q <= '0;
         end else begin
            rsp_cnt_q <= rsp_total;
         end
      end
   end

   // read data capture, per lane
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < n_lanes; i++) begin
         if (rvalid_i[i]) begin
            rdata_q[i*word_w +: word_w] <= lane_word(rdata_i, i);
         end
      end
   end

   // bypass the register for words arriving right now
   always_comb begin
      for (int i = 0; i < n_lanes; i++) begin
         if (rvalid_i[i]) begin
            word_now[i] = lane_word(rdata_i, i);
         end else begin
            word_now[i] = lane_word(rdata_q, i);
         end
      end
   end

   // release all responses together
   always_comb begin
      rvalid_o = '0;
      rdata_o  = '0;
      if (batch_done) begin
         rvalid_o = pending_q;
         for (int i = 0; i < n_lanes; i++) begin
            if (shared_q) begin
               rdata_o[i*word_w +: word_w] = word_now[0]; // broadcast core 0 data
            end else begin
               rdata_o[i*word_w +: word_w] = word_now[i];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* lockstep_unit.f */
hw/lockstep_pkg.sv
hw/grant_gather.sv
hw/response_gather.sv
hw/lockstep_unit.sv
verif/lockstep_unit_sva.sv
verif/tb_lockstep_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lockstep_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

top=tb_lockstep_unit
log=sim.log

verilator --binary --timing --assert \
   -f lockstep_unit.f \
   --top-module "$top" \
   -o "$top"

./obj_dir/"$top" | tee "$log"

if grep -q "all tests passed" "$log"; then
   exit 0
else
   echo "simulation did not pass, see $log"
   exit 1
fi

/* verif/lockstep_unit_sva.sv */
`timescale 1ns/10ps
`default_nettype none

// batch protocol checks around lockstep_unit
module lockstep_unit_sva import lockstep_pkg::*; (
   input wire logic       clk_i,
   input wire logic       rst_ni,
   input wire lane_mask_t req_i,
   input wire lane_mask_t gnt_i,
   input wire lane_mask_t gnt_o,
   input wire lane_mask_t rvalid_i,
   input wire lane_mask_t rvalid_o
);

   logic batch_open; // granted batch still waiting for its data

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         batch_open <= 1'b0;
      end else if (gnt_o != '0) begin
         batch_open <= 1'b1; // new batch may open as the old one completes
      end else if (rvalid_o != '0) begin
         batch_open <= 1'b0;
      end
   end

   // whole batch granted together, in the cycle of its last grant pulse
   gnt_whole_batch: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (gnt_o != '0) |-> ((gnt_o == req_i) && (gnt_i != '0)))
      else $error("gnt_o released off a grant pulse or not equal to the request mask");

   // responses belong to a batch granted in an earlier cycle
   rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (rvalid_o != '0) |-> batch_open)
      else $error("rvalid_o released in the grant cycle of its batch");

   // next batch may be granted as the last response comes in
   no_gnt_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (gnt_i != '0) |-> (!batch_open || (rvalid_o != '0)))
      else $error("memory granted while a batch is outstanding");

   no_rvalid_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (rvalid_i != '0) |-> batch_open)
      else $error("memory responded with no batch outstanding");

endmodule

bind lockstep_unit lockstep_unit_sva u_sva (
   .clk_i    (clk_i),
   .rst_ni   (rst_ni),
   .req_i    (req_i),
   .gnt_i    (gnt_i),
   .gnt_o    (gnt_o),
   .rvalid_i (rvalid_i),
   .rvalid_o (rvalid_o)
);

`default_nettype wire

/* verif/tb_lockstep_unit.sv */
`timescale 1ns/10ps
`default_nettype none

// batch level testbench for lockstep_unit, random memory model behind it
module tb_lockstep_unit import lockstep_pkg::*; ();

   localparam int n_batches  = 60;
   localparam int max_cycles = 2000; // reset + 60 batches of at most ~14 cycles, with margin
   // directed corner masks first: single lanes, with and without lane 0
   localparam lane_mask_t dir_mask [8] = '{8'h01, 8'h01, 8'h80, 8'h80,
                                           8'hfe, 8'hfe, 8'hff, 8'hff};
   localparam logic [7:0] dir_shared = 8'b1010_1010; // bit b is the mode of batch b

   logic       clk_i;
   logic       rst_ni;
   logic       same_address;
   lane_mask_t req_i, gnt_i, rvalid_i;
   lane_data_t rdata_i;
   lane_mask_t req_o, gnt_o, rvalid_o;
   lane_data_t rdata_o;

   // expected outputs for the current cycle
   lane_mask_t exp_req, exp_gnt, exp_rvalid;
   lane_data_t exp_rdata;
   lane_mask_t cmp_lanes; // rdata lanes that are compared
   logic       check_en;
   int         errors, checks, n_ok, n_bad, cycle_cnt;
   integer     seed;

   lockstep_unit DUT (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .same_address (same_address),
      .req_i        (req_i),
      .gnt_i        (gnt_i),
      .rvalid_i     (rvalid_i),
      .rdata_i      (rdata_i),
      .req_o        (req_o),
      .gnt_o        (gnt_o),
      .rvalid_o     (rvalid_o),
      .rdata_o      (rdata_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i; // 20 ns period
   end

   // expected batch result from mask, mode and the words memory returned
   function automatic void expect_batch(input lane_mask_t mask, input logic shared,
                                        input lane_data_t words, output lane_mask_t gnt,
                                        output lane_mask_t rvalid, output lane_data_t rdata);
      gnt    = mask; // every requester granted at once
      rvalid = mask;
      rdata  = '0;
      for (int i = 0; i < n_lanes; i++) begin
         if (shared) begin
            rdata[i*word_w +: word_w] = words[word_w-1:0]; // core 0 data to all
         end else if (mask[i]) begin
            rdata[i*word_w +: word_w] = words[i*word_w +: word_w];
         end
      end
   endfunction

   task automatic compare_outputs();
      checks++;
      if (req_o !== exp_req) begin
         errors++;
         $display("MISMATCH req_o: expected %h, got %h", exp_req, req_o);
      end
      if (gnt_o !== exp_gnt) begin
         errors++;
         $display("MISMATCH gnt_o: expected %h, got %h", exp_gnt, gnt_o);
      end
      if (rvalid_o !== exp_rvalid) begin
         errors++;
         $display("MISMATCH rvalid_o: expected %h, got %h", exp_rvalid, rvalid_o);
      end
      for (int i = 0; i < n_lanes; i++) begin
         if (cmp_lanes[i] && rdata_o[i*word_w +: word_w] !== exp_rdata[i*word_w +: word_w]) begin
            errors++;
            $display("MISMATCH rdata_o lane %0d: expected %h, got %h", i,
                     exp_rdata[i*word_w +: word_w], rdata_o[i*word_w +: word_w]);
         end
      end
   endtask

   // checker, samples mid cycle once inputs have settled
   initial begin
      forever begin
         @(negedge clk_i);
         #5;
         if (check_en) begin
            compare_outputs();
         end
      end
   end

   task automatic drive_idle();
      @(negedge clk_i);
      req_i        = '0;
      same_address = 1'b0;
      gnt_i        = '0;
      rvalid_i     = '0;
      rdata_i      = '0;
      exp_req      = '0;
      exp_gnt      = '0;
      exp_rvalid   = '0;
      exp_rdata    = '0; // rdata_o is zero outside a release
      cmp_lanes    = '1;
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) begin
         n_ok++;
         $display("%s: ok", name);
      end else begin
         n_bad++;
         $display("%s: FAILED with %0d mismatches", name, errors - err_before);
      end
   endtask

   // one batch: grants 0..3 cycles out, responses 1..4 cycles after release
   task automatic run_batch(input int idx, input lane_mask_t mask, input logic shared);
      int         gdelay [n_lanes];
      int         rdelay [n_lanes];
      int         rel, last, r, err_before;
      string      mode_s;
      lane_mask_t fwd, ref_gnt, ref_rvalid, gv, rv;
      lane_data_t words, ref_rdata, dv;
      err_before = errors;
      fwd   = shared ? lane_mask_t'(1) : mask; // only lane 0 goes out when shared
      rel   = 0;
      last  = 0;
      words = '0;
      for (int i = 0; i < n_lanes; i++) begin
         r         = $random(seed);
         gdelay[i] = r & 3;
         rdelay[i] = 1 + ((r >> 2) & 3);
         if (fwd[i]) begin
            words[i*word_w +: word_w] = $random(seed); // recorded memory word
            if (gdelay[i] > rel) begin
               rel = gdelay[i]; // release cycle = last grant
            end
         end
      end
      for (int i = 0; i < n_lanes; i++) begin
         if (fwd[i] && rel + rdelay[i] > last) begin
            last = rel + rdelay[i];
         end
      end
      expect_batch(mask, shared, words, ref_gnt, ref_rvalid, ref_rdata);
      for (int c = 0; c <= last; c++) begin
         @(negedge clk_i);
         for (int i = 0; i < n_lanes; i++) begin
            gv[i] = fwd[i] && (gdelay[i] == c);
            rv[i] = fwd[i] && (rel + rdelay[i] == c);
            if (rv[i]) begin
               dv[i*word_w +: word_w] = words[i*word_w +: word_w];
            end else begin
               dv[i*word_w +: word_w] = $random(seed); // junk on idle lanes
            end
         end
         req_i        = (c <= rel) ? mask : '0; // cores drop req after gnt_o
         same_address = shared;
         gnt_i        = gv;
         rvalid_i     = rv;
         rdata_i      = dv;
         exp_req      = (c <= rel) ? fwd : '0;
         exp_gnt      = (c == rel) ? ref_gnt : '0;
         exp_rvalid   = (c == last) ? ref_rvalid : '0;
         exp_rdata    = (c == last) ? ref_rdata : '0;
         if (c == last && !shared) begin
            cmp_lanes = ref_rvalid; // other lanes keep stale data
         end else begin
            cmp_lanes = '1;
         end
      end
      drive_idle();
      @(posedge clk_i); // last check done
      if (shared) begin
         mode_s = "shared";
      end else begin
         mode_s = "indep";
      end
      report_test($sformatf("batch %0d mask %h %s", idx, mask, mode_s), err_before);
   endtask

   initial begin
      int         r, err_before;
      lane_mask_t mask;
      logic       shared;
      seed         = 32'ha1dc_8b85;
      rst_ni       = 1'b0;
      same_address = 1'b0;
      req_i        = '0;
      gnt_i        = '0;
      rvalid_i     = '0;
      rdata_i      = '0;
      exp_req      = '0;
      exp_gnt      = '0;
      exp_rvalid   = '0;
      exp_rdata    = '0;
      cmp_lanes    = '1;
      check_en     = 1'b0;
      errors       = 0;
      checks       = 0;
      n_ok         = 0;
      n_bad        = 0;
      repeat (8) @(negedge clk_i);
      rst_ni   = 1'b1;
      check_en = 1'b1;

      // quiet after reset
      err_before = errors;
      repeat (4) drive_idle();
      @(posedge clk_i);
      report_test("reset idle", err_before);

      for (int b = 0; b < n_batches; b++) begin
         if (b < 8) begin
            mask   = dir_mask[b];
            shared = dir_shared[b];
         end else begin
            mask = '0;
            while (mask == '0) begin
               r      = $random(seed);
               mask   = lane_mask_t'(r);
               shared = r[8];
            end
         end
         run_batch(b, mask, shared);
      end

      $display("%0d tests run, %0d ok, %0d failing, %0d checks, %0d mismatches",
               n_ok + n_bad, n_ok, n_bad, checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < max_cycles) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire
